/* design/ppu_cfg.svh */
`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// Frame geometry, kept short so a simulation sees several frames
// Dots per line
`define PPU_DOTS_PER_LINE 16
// First dot of the horizontal blank on a visible line
`define PPU_HBLANK_DOT 12
// Lines with rendering
`define PPU_VISIBLE_LINES 6
// Idle line between render and vblank
`define PPU_POST_LINES 1
// Lines in vertical blank
`define PPU_VBLANK_LINES 3

// CPU register window, mirrored every 8 bytes
`define PPU_REG_BASE 16'h2000
`define PPU_REG_TOP 16'h3FFF

// NMI enable in the control register
`define PPU_NMI_BIT 7

`endif

/* design/ppu_pkg.sv */
package ppu_pkg;

	// Frame phase code seen by the status latch
	typedef enum logic [2:0] {
		ps_idle    = 3'd0,
		ps_restart = 3'd1,
		ps_render  = 3'd2,
		ps_hblank  = 3'd3,
		ps_post    = 3'd4,
		ps_vblank  = 3'd5,
		ps_vwait   = 3'd6
	} ppu_state_e;

	// Register select, taken from the low three address bits
	typedef enum logic [2:0] {
		rs_ctrl     = 3'd0,
		rs_mask     = 3'd1,
		rs_status   = 3'd2,
		rs_oam_addr = 3'd3,
		rs_oam_data = 3'd4,
		rs_scroll   = 3'd5,
		rs_addr     = 3'd6,
		rs_data     = 3'd7
	} reg_sel_e;

endpackage

/* design/ppu_reg_decode.sv */
`include "ppu_cfg.svh"

module ppu_reg_decode (
	input  logic               clk,
	input  logic               rst,
	input  logic [15:0]        cpu_addr,
	input  logic               cpu_rd,
	input  logic               cpu_wr,
	input  logic [7:0]         cpu_wdata,
	output logic               acc_rd,
	output logic               acc_wr,
	output ppu_pkg::reg_sel_e  acc_sel,
	output logic [7:0]         acc_wdata
);
	import ppu_pkg::*;

	logic     in_window;
	reg_sel_e sel_nxt;

	// Address falls inside the PPU register window
	assign in_window = (cpu_addr >= `PPU_REG_BASE) && (cpu_addr <= `PPU_REG_TOP);

	// Only the low three bits pick the register
	// so the window repeats every 8 bytes
	assign sel_nxt = reg_sel_e'(cpu_addr[2:0]);

	// Access strobes, dropped outside the window
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc_rd <= 1'b0;
			acc_wr <= 1'b0;
		end else begin
			acc_rd <= cpu_rd & in_window;
			acc_wr <= cpu_wr & in_window;
		end
	end

	// Select and write data ride along with the strobes
	// Only meaningful while a strobe is high
	always_ff @(posedge clk) begin
		acc_sel   <= sel_nxt;
		acc_wdata <= cpu_wdata;
	end

endmodule

/* design/ppu_frame_seq.sv */
`include "ppu_cfg.svh"

module ppu_frame_seq (
	input  logic                clk,
	input  logic                rst,
	output ppu_pkg::ppu_state_e ppu_state
);
	import ppu_pkg::*;

	localparam int DOTS     = `PPU_DOTS_PER_LINE;
	localparam int HBL_DOT  = `PPU_HBLANK_DOT;
	localparam int VIS      = `PPU_VISIBLE_LINES;
	localparam int POST     = `PPU_POST_LINES;
	localparam int LINES    = VIS + POST + `PPU_VBLANK_LINES;
	localparam int DOT_W    = $clog2(DOTS);
	localparam int LINE_W   = $clog2(LINES);

	logic [DOT_W-1:0]  dot_cnt;
	logic [DOT_W-1:0]  dot_nxt;
	logic [LINE_W-1:0] line_cnt;
	logic [LINE_W-1:0] line_nxt;
	ppu_state_e        state_nxt;

	// Position of the next cycle
	// Held at the origin while idle, so the first step lands on restart
	always_comb begin
		dot_nxt  = dot_cnt;
		line_nxt = line_cnt;
		if (ppu_state != ps_idle) begin
			if (dot_cnt == DOT_W'(DOTS - 1)) begin
				dot_nxt = '0;
				// Wrap to line 0 at end of frame
				if (line_cnt == LINE_W'(LINES - 1)) begin
					line_nxt = '0;
				end else begin
					line_nxt = line_cnt + LINE_W'(1);
				end
			end else begin
				dot_nxt = dot_cnt + DOT_W'(1);
			end
		end
	end

	// Phase for the next position
	always_comb begin
		if (dot_nxt == '0 && line_nxt == '0) begin
			// Single cycle marker at frame start
			state_nxt = ps_restart;
		end else if (line_nxt < LINE_W'(VIS)) begin
			// Visible line, tail is hblank
			state_nxt = (dot_nxt < DOT_W'(HBL_DOT)) ? ps_render : ps_hblank;
		end else if (line_nxt < LINE_W'(VIS + POST)) begin
			state_nxt = ps_post;
		end else if (line_nxt == LINE_W'(VIS + POST) && dot_nxt == '0) begin
			// Single cycle marker entering vblank
			state_nxt = ps_vblank;
		end else begin
			state_nxt = ps_vwait;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			dot_cnt   <= '0;
			line_cnt  <= '0;
			ppu_state <= ps_idle;
		end else begin
			dot_cnt   <= dot_nxt;
			line_cnt  <= line_nxt;
			ppu_state <= state_nxt;
		end
	end

endmodule

/* design/ppu_status_latch.sv */
module ppu_status_latch (
	input  logic                clk,
	input  logic                rst,
	input  logic                sprite_0_hit,
	input  logic                sprite_overflow,
	input  ppu_pkg::ppu_state_e ppu_state,
	input  logic                status_rd,
	output logic [2:0]          status_flags
);
	import ppu_pkg::*;

	logic       vblank_flag;
	logic [1:0] spr_in;
	logic [1:0] spr_flag;

	// Bit 1 is sprite 0 hit, bit 0 is overflow
	assign spr_in = {sprite_0_hit, sprite_overflow};

	// Ordered vblank, hit, overflow
	assign status_flags = {vblank_flag, spr_flag};

	// Sprite flags
	// Set by their input while clear, cleared at restart while set
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			spr_flag <= 2'b00;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (!spr_flag[i]) begin
					if (spr_in[i]) begin
						spr_flag[i] <= 1'b1;
					end
				end else if (ppu_state == ps_restart) begin
					spr_flag[i] <= 1'b0;
				end
			end
		end
	end

	// Vblank flag
	// Set entering vblank, cleared at restart or by a status read
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			vblank_flag <= 1'b0;
		end else begin
			if (!vblank_flag) begin
				if (ppu_state == ps_vblank) begin
					vblank_flag <= 1'b1;
				end
			end else if (ppu_state == ps_restart || status_rd) begin
				// Clears on the same edge that captures the read byte
				vblank_flag <= 1'b0;
			end
		end
	end

endmodule

/* design/ppu_ctrl_regs.sv */
`include "ppu_cfg.svh"

module ppu_ctrl_regs (
	input  logic              clk,
	input  logic              rst,
	input  logic              acc_rd,
	input  logic              acc_wr,
	input  ppu_pkg::reg_sel_e acc_sel,
	input  logic [7:0]        acc_wdata,
	input  logic [2:0]        status_flags,
	output logic              status_rd,
	output logic [7:0]        ppu_ctrl,
	output logic [7:0]        ppu_mask,
	output logic [7:0]        cpu_rdata,
	output logic              nmi
);
	import ppu_pkg::*;

	logic [7:0] rd_byte;

	// Read of $2002, tells the latch to drop vblank
	assign status_rd = acc_rd && (acc_sel == rs_status);

	// Flags in the top three bits, low five read as zero
	// Every other register reads zero
	assign rd_byte = (acc_sel == rs_status) ? {status_flags, 5'b00000} : 8'h00;

	// NMI follows vblank while enabled
	assign nmi = status_flags[2] & ppu_ctrl[`PPU_NMI_BIT];

	// Control and mask writes, other selects ignored
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ppu_ctrl <= 8'h00;
			ppu_mask <= 8'h00;
		end else if (acc_wr) begin
			case (acc_sel)
				rs_ctrl: ppu_ctrl <= acc_wdata;
				rs_mask: ppu_mask <= acc_wdata;
				default: ;
			endcase
		end
	end

	// Read data register
	// holds the last read byte between reads
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cpu_rdata <= 8'h00;
		end else if (acc_rd) begin
			cpu_rdata <= rd_byte;
		end
	end

endmodule

/* design/ppu_regs_top.sv */
module ppu_regs_top (
	input  logic                clk,
	input  logic                rst,
	input  logic [15:0]         cpu_addr,
	input  logic                cpu_rd,
	input  logic                cpu_wr,
	input  logic [7:0]          cpu_wdata,
	input  logic                sprite_0_hit,
	input  logic                sprite_overflow,
	output logic [7:0]          cpu_rdata,
	output logic [7:0]          ppu_ctrl,
	output logic [7:0]          ppu_mask,
	output logic                nmi,
	output ppu_pkg::ppu_state_e ppu_state
);
	import ppu_pkg::*;

	// Decoded access
	logic       acc_rd;
	logic       acc_wr;
	reg_sel_e   acc_sel;
	logic [7:0] acc_wdata;

	// Between control registers and status latch
	logic       status_rd;
	logic [2:0] status_flags;

	// CPU access decode, first pipeline stage
	ppu_reg_decode decode_i (
		.clk       (clk),
		.rst       (rst),
		.cpu_addr  (cpu_addr),
		.cpu_rd    (cpu_rd),
		.cpu_wr    (cpu_wr),
		.cpu_wdata (cpu_wdata),
		.acc_rd    (acc_rd),
		.acc_wr    (acc_wr),
		.acc_sel   (acc_sel),
		.acc_wdata (acc_wdata)
	);

	// Frame phase generator
	ppu_frame_seq frame_seq_i (
		.clk       (clk),
		.rst       (rst),
		.ppu_state (ppu_state)
	);

	// $2002 flags
	ppu_status_latch status_latch_i (
		.clk             (clk),
		.rst             (rst),
		.sprite_0_hit    (sprite_0_hit),
		.sprite_overflow (sprite_overflow),
		.ppu_state       (ppu_state),
		.status_rd       (status_rd),
		.status_flags    (status_flags)
	);

	// Control, mask, read data and NMI
	ppu_ctrl_regs ctrl_regs_i (
		.clk          (clk),
		.rst          (rst),
		.acc_rd       (acc_rd),
		.acc_wr       (acc_wr),
		.acc_sel      (acc_sel),
		.acc_wdata    (acc_wdata),
		.status_flags (status_flags),
		.status_rd    (status_rd),
		.ppu_ctrl     (ppu_ctrl),
		.ppu_mask     (ppu_mask),
		.cpu_rdata    (cpu_rdata),
		.nmi          (nmi)
	);

endmodule

/* sim/ppu_sva.sv */
`include "ppu_cfg.svh"

module ppu_sva #(
	parameter bit flag_rules = 1'b1
) (
	input logic                clk,
	input logic                rst,
	input ppu_pkg::ppu_state_e ppu_state,
	input logic [2:0]          status_flags,
	input logic [7:0]          ppu_ctrl,
	input logic [7:0]          cpu_rdata,
	input logic                nmi
);
	import ppu_pkg::*;

	if (flag_rules) begin : g_flag
		// Vblank only rises right after the vblank marker
		vblank_rise_a: assert property (@(posedge clk) disable iff (!rst)
			$rose(status_flags[2]) |-> $past(ppu_state) == ps_vblank)
			else $error("vblank flag rose without ps_vblank");

		// Frame start wipes every flag
		restart_clear_a: assert property (@(posedge clk) disable iff (!rst)
			ppu_state == ps_restart |=> status_flags == 3'b000)
			else $error("status flags still set after ps_restart");
	end else begin : g_ctrl
		// NMI is vblank gated by the enable bit
		nmi_a: assert property (@(posedge clk) disable iff (!rst)
			nmi == (status_flags[2] & ppu_ctrl[`PPU_NMI_BIT]))
			else $error("nmi does not match vblank and enable");

		// Low five bits of read data stay zero
		rdata_low_a: assert property (@(posedge clk) disable iff (!rst)
			cpu_rdata[4:0] == 5'b00000)
			else $error("cpu_rdata low bits not zero");
	end

endmodule

// Flag rules on the status latch
bind ppu_status_latch ppu_sva #(.flag_rules(1'b1)) flag_sva_i (
	.clk          (clk),
	.rst          (rst),
	.ppu_state    (ppu_state),
	.status_flags (status_flags),
	.ppu_ctrl     (8'h00),
	.cpu_rdata    (8'h00),
	.nmi          (1'b0)
);

// NMI and read data rules on the control registers
bind ppu_ctrl_regs ppu_sva #(.flag_rules(1'b0)) ctrl_sva_i (
	.clk          (clk),
	.rst          (rst),
	.ppu_state    (ppu_pkg::ps_idle),
	.status_flags (status_flags),
	.ppu_ctrl     (ppu_ctrl),
	.cpu_rdata    (cpu_rdata),
	.nmi          (nmi)
);

/* sim/ppu_tb.sv */
`include "ppu_cfg.svh"

module ppu_tb;
	import ppu_pkg::*;

	// One frame in cycles, four frames allowed per test
	localparam int frame_cycles = `PPU_DOTS_PER_LINE *
		(`PPU_VISIBLE_LINES + `PPU_POST_LINES + `PPU_VBLANK_LINES);
	localparam int num_tests    = 5;
	localparam int reset_cycles = 16;
	localparam int cycle_limit  = num_tests * 4 * frame_cycles + reset_cycles;

	logic        clk;
	logic        rst;
	logic [15:0] cpu_addr;
	logic        cpu_rd;
	logic        cpu_wr;
	logic [7:0]  cpu_wdata;
	logic        sprite_0_hit;
	logic        sprite_overflow;
	logic [7:0]  cpu_rdata;
	logic [7:0]  ppu_ctrl;
	logic [7:0]  ppu_mask;
	logic        nmi;
	ppu_state_e  ppu_state;

	int cycle_cnt;
	int checks;
	int errors;
	int test_errs;
	int tests_failed;

	// Frame phase tracking
	int         since_restart;
	bit         restart_seen;
	ppu_state_e prev_state;

	ppu_regs_top dut_i (
		.clk             (clk),
		.rst             (rst),
		.cpu_addr        (cpu_addr),
		.cpu_rd          (cpu_rd),
		.cpu_wr          (cpu_wr),
		.cpu_wdata       (cpu_wdata),
		.sprite_0_hit    (sprite_0_hit),
		.sprite_overflow (sprite_overflow),
		.cpu_rdata       (cpu_rdata),
		.ppu_ctrl        (ppu_ctrl),
		.ppu_mask        (ppu_mask),
		.nmi             (nmi),
		.ppu_state       (ppu_state)
	);

	// 40 unit clock
	always #20 clk = ~clk;

	// Watchdog on the cycle count
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, stimulus did not complete", cycle_cnt);
		$display(">>> FAIL");
		$finish;
	end

	// Frame phase timing at the ports
	// Restart recurs once per frame, both markers last a single cycle
	always @(negedge clk) begin
		if (rst) begin
			if (prev_state == ps_restart && ppu_state != ps_render) begin
				$display("FAIL at %0t: ppu_state after ps_restart expected %0d, got %0d",
					$time, ps_render, ppu_state);
				test_errs++;
			end
			if (prev_state == ps_vblank && ppu_state != ps_vwait) begin
				$display("FAIL at %0t: ppu_state after ps_vblank expected %0d, got %0d",
					$time, ps_vwait, ppu_state);
				test_errs++;
			end
			if (ppu_state == ps_restart) begin
				if (restart_seen && since_restart != frame_cycles) begin
					$display("FAIL at %0t: ppu_state restart period expected %0d, got %0d",
						$time, frame_cycles, since_restart);
					test_errs++;
				end
				restart_seen  = 1'b1;
				since_restart = 1;
			end else begin
				since_restart++;
			end
			prev_state = ppu_state;
		end
	end

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			$display("FAIL at %0t: %s expected %02h, got %02h", $time, name, exp, act);
			test_errs++;
		end
	endtask

	// One-cycle strobe, then one more cycle for the second stage
	// Returns on the falling edge after the result is registered
	task automatic cpu_access(input logic is_wr, input logic [15:0] addr,
		input logic [7:0] data);
		cpu_addr  = addr;
		cpu_wdata = data;
		cpu_rd    = !is_wr;
		cpu_wr    = is_wr;
		@(negedge clk);
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		@(negedge clk);
	endtask

	task automatic run_step(input logic [7:0] action, input logic [15:0] addr,
		input logic [7:0] value);
		case (action)
			"W": cpu_access(1'b1, addr, value);
			"R": begin
				cpu_access(1'b0, addr, 8'h00);
				check_byte("cpu_rdata", value, cpu_rdata);
			end
			"S": begin
				// Level wait on the frame phase
				while (ppu_state != ppu_state_e'(value[2:0])) begin
					@(negedge clk);
				end
			end
			"P": begin
				sprite_0_hit    = value[1];
				sprite_overflow = value[0];
				@(negedge clk);
				sprite_0_hit    = 1'b0;
				sprite_overflow = 1'b0;
			end
			"C": begin
				case (addr)
					16'd0:   check_byte("ppu_ctrl", value, ppu_ctrl);
					16'd1:   check_byte("ppu_mask", value, ppu_mask);
					default: check_byte("nmi", value, {7'b0, nmi});
				endcase
			end
			default: begin
				$display("Unknown action %s in stimulus file", action);
				test_errs++;
			end
		endcase
	endtask

	task automatic report_test(input int num);
		if (test_errs == 0) begin
			$display("Test %0d passed", num);
		end else begin
			$display("Test %0d failed with %0d errors", num, test_errs);
			tests_failed++;
		end
		errors += test_errs;
		test_errs = 0;
	endtask

	initial begin
		int               fd;
		int               n;
		int               cur_test;
		int               test_num;
		logic [7:0]       action;
		logic [15:0]      addr;
		logic [7:0]       value;
		logic [8*256-1:0] line;
		bit               done;
		clk             = 1'b0;
		rst             = 1'b0;
		cpu_addr        = '0;
		cpu_rd          = 1'b0;
		cpu_wr          = 1'b0;
		cpu_wdata       = '0;
		sprite_0_hit    = 1'b0;
		sprite_overflow = 1'b0;
		checks          = 0;
		errors          = 0;
		test_errs       = 0;
		tests_failed    = 0;
		since_restart   = 0;
		restart_seen    = 1'b0;
		prev_state      = ps_idle;
		cur_test        = 0;
		done            = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b1;
		fd = $fopen("sim/ppu_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open stimulus file sim/ppu_stim.txt");
			$display(">>> FAIL");
			$finish;
		end else begin
			while (!done) begin
				n = $fscanf(fd, "%s", action);
				if (n != 1) begin
					done = 1'b1;
				end else if (action == "#") begin
					// Skip rest of a comment line
					n = $fgets(line, fd);
				end else begin
					n = $fscanf(fd, "%h %h %d", addr, value, test_num);
					if (n != 3) begin
						$display("Malformed line in stimulus file after test %0d", cur_test);
						test_errs++;
						done = 1'b1;
					end else begin
						// New test number closes the previous test
						if (test_num != cur_test && cur_test != 0) begin
							report_test(cur_test);
						end
						cur_test = test_num;
						run_step(action, addr, value);
					end
				end
			end
			$fclose(fd);
			// Half a cycle on, past the phase check of the last falling edge
			@(posedge clk);
			report_test(cur_test);
			$display("Tests %0d, failed %0d, checks %0d, errors %0d",
				cur_test, tests_failed, checks, errors);
			if (errors == 0) begin
				$display(">>> PASS");
			end else begin
				$display(">>> FAIL");
			end
			$finish;
		end
	end

endmodule

/* project.f */
+incdir+design
design/ppu_pkg.sv
design/ppu_reg_decode.sv
design/ppu_frame_seq.sv
design/ppu_status_latch.sv
design/ppu_ctrl_regs.sv
design/ppu_regs_top.sv
sim/ppu_sva.sv
sim/ppu_tb.sv

/* Makefile */
TOP = ppu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qF ">>> PASS"

clean:
	rm -rf obj_dir

/* sim/ppu_stim.txt */
# act addr data test: W write, R read with expected byte, S wait for state code
# P sprite pulse (data bit 1 hit, bit 0 overflow), C check port (addr 0 ctrl, 1 mask, 2 nmi)
R 2002 00 1
C 0002 00 1
W 2008 5a 1
C 0000 5a 1
R 2000 00 1
S 0000 06 2
R 2002 80 2
R 2002 00 2
S 0000 02 3
P 0000 02 3
P 0000 01 3
R 2002 60 3
S 0000 01 3
R 2002 00 3
W 2000 80 4
C 0002 00 4
S 0000 06 4
C 0002 01 4
R 2002 80 4
C 0002 00 4
W 2001 3c 5
W 1002 ff 5
W 2005 ff 5
C 0000 80 5
C 0001 3c 5
S 0000 02 5
S 0000 06 5
R 4002 80 5
C 0002 01 5
R 2002 80 5
